/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = rv_core_tb
FILELIST  = rv_core.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* core_pkg.sv */
package core_pkg;

  // datapath and address width
  localparam int xlen = 64;
  // instruction word width
  localparam int ilen = 32;
  // register index width
  localparam int reg_addr_w = 5;

  // first fetch address after reset
  localparam logic [xlen-1:0] reset_pc = 64'h0000_0000_8000_0000;

  // major opcodes of the supported subset
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_lui = 7'b0110111;
  localparam logic [6:0] opc_auipc = 7'b0010111;
  localparam logic [6:0] opc_jal = 7'b1101111;
  localparam logic [6:0] opc_system = 7'b1110011;

  // funct3 of addi
  localparam logic [2:0] funct3_addi = 3'b000;

  // ebreak has a single fixed encoding
  localparam logic [ilen-1:0] inst_ebreak_word = 32'h0010_0073;

  // operation codes from decode to execute
  localparam logic [7:0] exu_op_add = 8'h11;
  localparam logic [7:0] exu_op_nop = 8'h00;

  // bit positions in the one-hot instruction class
  localparam int cls_r = 0;
  localparam int cls_i = 1;
  localparam int cls_s = 2;
  localparam int cls_b = 3;
  localparam int cls_u = 4;
  localparam int cls_j = 5;

endpackage

/* exu.sv */
`timescale 1ns/1ps

module exu (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             ex_valid_in,
  input  logic [7:0]                       exu_op,
  input  logic [core_pkg::xlen-1:0]        op1,
  input  logic [core_pkg::xlen-1:0]        op2,
  input  logic                             rd_w_en,
  input  logic [core_pkg::reg_addr_w-1:0]  rd_w_addr,
  input  logic                             is_ebreak,
  input  logic [core_pkg::xlen-1:0]        pc_in,
  output logic                             wb_en,
  output logic [core_pkg::reg_addr_w-1:0]  wb_addr,
  output logic [core_pkg::xlen-1:0]        wb_data,
  output logic                             retire_valid,
  output logic [core_pkg::xlen-1:0]        retire_pc,
  output logic [core_pkg::reg_addr_w-1:0]  retire_rd,
  output logic                             retire_wen,
  output logic [core_pkg::xlen-1:0]        retire_data,
  output logic                             halted
);

  logic                            ex_valid;
  logic [7:0]                      ex_op;
  logic [core_pkg::xlen-1:0]       ex_op1;
  logic [core_pkg::xlen-1:0]       ex_op2;
  logic                            ex_rd_w_en;
  logic [core_pkg::reg_addr_w-1:0] ex_rd;
  logic                            ex_ebreak;
  logic [core_pkg::xlen-1:0]       ex_pc;
  logic                            hold;
  logic [core_pkg::xlen-1:0]       result;

  // nothing enters once ebreak has reached execute
  assign hold = halted | (ex_valid & ex_ebreak);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_valid <= 1'b0;
      halted <= 1'b0;
    end else begin
      ex_valid <= hold ? 1'b0 : ex_valid_in;
      if (ex_valid && ex_ebreak) begin
        halted <= 1'b1;
      end
    end
  end

  // decode-to-execute payload
  always_ff @(posedge clk) begin
    if (!hold) begin
      ex_op <= exu_op;
      ex_op1 <= op1;
      ex_op2 <= op2;
      ex_rd_w_en <= rd_w_en;
      ex_rd <= rd_w_addr;
      ex_ebreak <= is_ebreak;
      ex_pc <= pc_in;
    end
  end

  always_comb begin
    case (ex_op)
      core_pkg::exu_op_add: result = ex_op1 + ex_op2;
      core_pkg::exu_op_nop: result = '0;
      default: result = '0;
    endcase
  end

  // writeback and retire report
  assign wb_en = ex_valid & ex_rd_w_en;
  assign wb_addr = ex_rd;
  assign wb_data = result;

  assign retire_valid = ex_valid;
  assign retire_pc = ex_pc;
  assign retire_rd = ex_rd;
  assign retire_wen = ex_valid & ex_rd_w_en;
  assign retire_data = result;

endmodule

/* idu.sv */
`timescale 1ns/1ps

module idu (
  input  logic                             id_valid,
  input  logic [core_pkg::xlen-1:0]        pc,
  input  logic [core_pkg::ilen-1:0]        inst,
  input  logic [core_pkg::xlen-1:0]        rs1_data,
  output logic [7:0]                       exu_op,
  output logic [core_pkg::xlen-1:0]        op1,
  output logic [core_pkg::xlen-1:0]        op2,
  output logic                             rs1_r_en,
  output logic [core_pkg::reg_addr_w-1:0]  rs1_r_addr,
  output logic                             rd_w_en,
  output logic [core_pkg::reg_addr_w-1:0]  rd_w_addr,
  output logic                             is_ebreak,
  output logic                             ex_valid_in,
  output logic                             redirect,
  output logic [core_pkg::xlen-1:0]        redirect_pc,
  output logic [core_pkg::xlen-1:0]        pc_out
);

  logic [6:0]                      opcode;
  logic [core_pkg::reg_addr_w-1:0] rd;
  logic [2:0]                      funct3;
  logic [core_pkg::reg_addr_w-1:0] rs1;
  logic [11:0]                     imm_i;
  logic [19:0]                     imm_u_j;
  logic [core_pkg::xlen-1:0]       src_i;
  logic [core_pkg::xlen-1:0]       src_u;
  logic [core_pkg::xlen-1:0]       src_j;
  logic                            inst_addi;
  logic                            inst_lui;
  logic                            inst_auipc;
  logic                            inst_jal;
  logic                            inst_ebreak;
  logic [5:0]                      inst_class;
  logic                            known;

  // field split
  assign opcode = inst[6:0];
  assign rd = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1 = inst[19:15];
  assign imm_i = inst[31:20];
  assign imm_u_j = inst[31:12];

  // immediates sign extended to xlen
  assign src_i = {{52{imm_i[11]}}, imm_i};
  assign src_u = {{32{imm_u_j[19]}}, imm_u_j, 12'b0};
  // J layout is imm[20|10:1|11|19:12] in inst[31:12]
  assign src_j = {{44{imm_u_j[19]}}, imm_u_j[7:0], imm_u_j[8], imm_u_j[18:9], 1'b0};

  // instruction detection
  assign inst_addi = (opcode == core_pkg::opc_op_imm) && (funct3 == core_pkg::funct3_addi);
  assign inst_lui = (opcode == core_pkg::opc_lui);
  assign inst_auipc = (opcode == core_pkg::opc_auipc);
  assign inst_jal = (opcode == core_pkg::opc_jal);
  assign inst_ebreak = (opcode == core_pkg::opc_system) &&
                       (inst[31:7] == core_pkg::inst_ebreak_word[31:7]);

  // one-hot class where only I, U and J occur in this subset
  assign inst_class[core_pkg::cls_r] = 1'b0;
  assign inst_class[core_pkg::cls_i] = inst_addi | inst_ebreak;
  assign inst_class[core_pkg::cls_s] = 1'b0;
  assign inst_class[core_pkg::cls_b] = 1'b0;
  assign inst_class[core_pkg::cls_u] = inst_lui | inst_auipc;
  assign inst_class[core_pkg::cls_j] = inst_jal;

  assign known = |inst_class;

  assign ex_valid_in = id_valid & known;
  assign is_ebreak = id_valid & inst_ebreak;
  // ebreak and unknown words do no arithmetic
  assign exu_op = (id_valid && known && !inst_ebreak) ? core_pkg::exu_op_add
                                                      : core_pkg::exu_op_nop;

  // jal resolved in decode with one bubble behind it
  assign redirect = id_valid & inst_jal;
  assign redirect_pc = pc + src_j;
  assign pc_out = pc;

  // operands and register enables
  always_comb begin
    op1 = '0;
    op2 = '0;
    rs1_r_en = 1'b0;
    rs1_r_addr = '0;
    rd_w_en = 1'b0;
    rd_w_addr = '0;
    if (id_valid) begin
      if (inst_class[core_pkg::cls_i]) begin
        // ebreak is I-class but reads and writes nothing
        if (!inst_ebreak) begin
          op1 = rs1_data;
          op2 = src_i;
          rs1_r_en = 1'b1;
          rs1_r_addr = rs1;
          rd_w_en = 1'b1;
          rd_w_addr = rd;
        end
      end else if (inst_class[core_pkg::cls_u]) begin
        // lui adds to zero and auipc to its own pc
        op1 = inst_auipc ? pc : '0;
        op2 = src_u;
        rd_w_en = 1'b1;
        rd_w_addr = rd;
      end else if (inst_class[core_pkg::cls_j]) begin
        // link value
        op1 = pc;
        op2 = 64'd4;
        rd_w_en = 1'b1;
        rd_w_addr = rd;
      end
    end
  end

endmodule

/* ifu.sv */
`timescale 1ns/1ps

module ifu (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [core_pkg::ilen-1:0]  inst_data,
  input  logic                       redirect,
  input  logic [core_pkg::xlen-1:0]  redirect_pc,
  input  logic                       halted,
  output logic [core_pkg::xlen-1:0]  inst_addr,
  output logic                       id_valid,
  output logic [core_pkg::xlen-1:0]  id_pc,
  output logic [core_pkg::ilen-1:0]  id_inst
);

  logic [core_pkg::xlen-1:0] pc;

  assign inst_addr = pc;

  // program counter and decode valid
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= core_pkg::reset_pc;
      id_valid <= 1'b0;
    end else if (halted) begin
      // pc frozen and decode entry emptied
      id_valid <= 1'b0;
    end else if (redirect) begin
      // word fetched behind the jal is dropped
      pc <= redirect_pc;
      id_valid <= 1'b0;
    end else begin
      pc <= pc + 64'd4;
      id_valid <= 1'b1;
    end
  end

  // fetched word and its address
  always_ff @(posedge clk) begin
    if (!halted) begin
      id_pc <= pc;
      id_inst <= inst_data;
    end
  end

endmodule

/* regfile.sv */
`timescale 1ns/1ps

module regfile (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             rs1_r_en,
  input  logic [core_pkg::reg_addr_w-1:0]  rs1_r_addr,
  input  logic                             wb_en,
  input  logic [core_pkg::reg_addr_w-1:0]  wb_addr,
  input  logic [core_pkg::xlen-1:0]        wb_data,
  output logic [core_pkg::xlen-1:0]        rs1_data
);

  logic [core_pkg::xlen-1:0] regs [0:31];

  // write port that never writes x0
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en && (wb_addr != '0)) begin
      regs[wb_addr] <= wb_data;
    end
  end

  // read port with write-through
  always_comb begin
    if (!rs1_r_en || (rs1_r_addr == '0)) begin
      rs1_data = '0;
    end else if (wb_en && (wb_addr == rs1_r_addr)) begin
      // value being retired this cycle
      rs1_data = wb_data;
    end else begin
      rs1_data = regs[rs1_r_addr];
    end
  end

endmodule

/* rv_core.f */
core_pkg.sv
ifu.sv
idu.sv
regfile.sv
exu.sv
rv_core.sv
rv_core_tb.sv

/* rv_core.sv */
`timescale 1ns/1ps

module rv_core (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [core_pkg::ilen-1:0]        inst_data,
  output logic [core_pkg::xlen-1:0]        inst_addr,
  output logic                             retire_valid,
  output logic [core_pkg::xlen-1:0]        retire_pc,
  output logic [core_pkg::reg_addr_w-1:0]  retire_rd,
  output logic                             retire_wen,
  output logic [core_pkg::xlen-1:0]        retire_data,
  output logic                             halted
);

  // fetch to decode
  logic                            id_valid;
  logic [core_pkg::xlen-1:0]       id_pc;
  logic [core_pkg::ilen-1:0]       id_inst;
  logic                            redirect;
  logic [core_pkg::xlen-1:0]       redirect_pc;

  // decode to register file
  logic                            rs1_r_en;
  logic [core_pkg::reg_addr_w-1:0] rs1_r_addr;
  logic [core_pkg::xlen-1:0]       rs1_data;

  // decode to execute
  logic                            ex_valid_in;
  logic [7:0]                      exu_op;
  logic [core_pkg::xlen-1:0]       op1;
  logic [core_pkg::xlen-1:0]       op2;
  logic                            rd_w_en;
  logic [core_pkg::reg_addr_w-1:0] rd_w_addr;
  logic                            is_ebreak;
  logic [core_pkg::xlen-1:0]       pc_out;

  // writeback
  logic                            wb_en;
  logic [core_pkg::reg_addr_w-1:0] wb_addr;
  logic [core_pkg::xlen-1:0]       wb_data;

  ifu u_ifu (
    .clk         (clk),
    .rst_n       (rst_n),
    .inst_data   (inst_data),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .halted      (halted),
    .inst_addr   (inst_addr),
    .id_valid    (id_valid),
    .id_pc       (id_pc),
    .id_inst     (id_inst)
  );

  idu u_idu (
    .id_valid    (id_valid),
    .pc          (id_pc),
    .inst        (id_inst),
    .rs1_data    (rs1_data),
    .exu_op      (exu_op),
    .op1         (op1),
    .op2         (op2),
    .rs1_r_en    (rs1_r_en),
    .rs1_r_addr  (rs1_r_addr),
    .rd_w_en     (rd_w_en),
    .rd_w_addr   (rd_w_addr),
    .is_ebreak   (is_ebreak),
    .ex_valid_in (ex_valid_in),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .pc_out      (pc_out)
  );

  regfile u_regfile (
    .clk        (clk),
    .rst_n      (rst_n),
    .rs1_r_en   (rs1_r_en),
    .rs1_r_addr (rs1_r_addr),
    .wb_en      (wb_en),
    .wb_addr    (wb_addr),
    .wb_data    (wb_data),
    .rs1_data   (rs1_data)
  );

  exu u_exu (
    .clk          (clk),
    .rst_n        (rst_n),
    .ex_valid_in  (ex_valid_in),
    .exu_op       (exu_op),
    .op1          (op1),
    .op2          (op2),
    .rd_w_en      (rd_w_en),
    .rd_w_addr    (rd_w_addr),
    .is_ebreak    (is_ebreak),
    .pc_in        (pc_out),
    .wb_en        (wb_en),
    .wb_addr      (wb_addr),
    .wb_data      (wb_data),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_wen   (retire_wen),
    .retire_data  (retire_data),
    .halted       (halted)
  );

endmodule

/* rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb;

  typedef struct packed {
    logic [63:0] pc;
    logic [4:0]  rd;
    logic        wen;
    logic [63:0] data;
  } retire_rec_t;

  logic        clk;
  logic        rst_n;
  logic [31:0] inst_data;
  logic [63:0] inst_addr;
  logic        retire_valid;
  logic [63:0] retire_pc;
  logic [4:0]  retire_rd;
  logic        retire_wen;
  logic [63:0] retire_data;
  logic        halted;

  logic [31:0] prog [0:255];
  logic [7:0]  prog_len;
  logic [63:0] fetch_idx;
  retire_rec_t exp_q [$];
  retire_rec_t mon_rec;
  logic [31:0] lfsr_state;
  int          errors;
  int          checks;
  int          n_tests = 6;

  rv_core dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .inst_data    (inst_data),
    .inst_addr    (inst_addr),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_wen   (retire_wen),
    .retire_data  (retire_data),
    .halted       (halted)
  );

  always #5 clk = ~clk;

  // instruction memory answering in the same cycle
  assign fetch_idx = (inst_addr - core_pkg::reset_pc) >> 2;

  always_comb begin
    if (fetch_idx < 64'd256) begin
      inst_data = prog[fetch_idx[7:0]];
    end else begin
      inst_data = 32'h0000_0013;
    end
  end

  // x^32 + x^22 + x^2 + x + 1 stepped once per bit
  function automatic logic [31:0] take_bits(int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      val = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic logic [4:0] rand_reg();
    logic [31:0] r;
    r = take_bits(5);
    return (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
  endfunction

  function automatic logic [11:0] rand_imm12();
    logic [31:0] r;
    r = take_bits(12);
    return r[11:0];
  endfunction

  function automatic logic [19:0] rand_imm20();
    logic [31:0] r;
    r = take_bits(20);
    return r[19:0];
  endfunction

  // instruction encoders
  function automatic logic [31:0] enc_addi(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] enc_lui(logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] enc_auipc(logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, 7'b0010111};
  endfunction

  function automatic logic [31:0] enc_jal(logic [4:0] rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_true(logic cond, string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("Check failed: %s", what);
    end
  endtask

  // instruction-level model that fills the expected retire queue
  task automatic run_model();
    logic [63:0] regs [0:31];
    logic [63:0] pc;
    logic [63:0] next_pc;
    logic [63:0] idx;
    logic [63:0] res;
    logic [31:0] w;
    logic        known;
    retire_rec_t rec;
    bit          done;
    int          steps;
    regs = '{default: 64'd0};
    pc = core_pkg::reset_pc;
    res = '0;
    done = 1'b0;
    steps = 0;
    exp_q.delete();
    while (!done && steps < 150) begin
      idx = (pc - core_pkg::reset_pc) >> 2;
      w = (idx < 64'd256) ? prog[idx[7:0]] : 32'h0000_0013;
      known = 1'b1;
      next_pc = pc + 64'd4;
      if (w == 32'h0010_0073) begin
        // ebreak retires without a write and stops the program
        rec = '{pc: pc, rd: 5'd0, wen: 1'b0, data: 64'd0};
        exp_q.push_back(rec);
        done = 1'b1;
        known = 1'b0;
      end else if (w[6:0] == 7'b0010011 && w[14:12] == 3'b000) begin
        res = regs[w[19:15]] + {{52{w[31]}}, w[31:20]};
      end else if (w[6:0] == 7'b0110111) begin
        res = {{32{w[31]}}, w[31:12], 12'h000};
      end else if (w[6:0] == 7'b0010111) begin
        res = pc + {{32{w[31]}}, w[31:12], 12'h000};
      end else if (w[6:0] == 7'b1101111) begin
        res = pc + 64'd4;
        next_pc = pc + {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      end else begin
        known = 1'b0;
      end
      if (known) begin
        rec = '{pc: pc, rd: w[11:7], wen: 1'b1, data: res};
        exp_q.push_back(rec);
        if (w[11:7] != 5'd0) begin
          regs[w[11:7]] = res;
        end
      end
      pc = next_pc;
      steps++;
    end
  endtask

  // retire monitor sampled mid-cycle
  always @(negedge clk) begin
    if (rst_n && retire_valid) begin
      checks++;
      assert (exp_q.size() > 0) else begin
        errors++;
        $display("Unexpected retire at pc %h", retire_pc);
      end
      if (exp_q.size() > 0) begin
        mon_rec = exp_q.pop_front();
        check_value("retire_pc", retire_pc, mon_rec.pc);
        check_value("retire_wen", {63'd0, retire_wen}, {63'd0, mon_rec.wen});
        if (mon_rec.wen) begin
          check_value("retire_rd", {59'd0, retire_rd}, {59'd0, mon_rec.rd});
          check_value("retire_data", retire_data, mon_rec.data);
        end
      end
    end
  end

  task automatic begin_test(string name);
    @(posedge clk);
    #1;
    rst_n = 1'b0;
    prog = '{default: 32'h0000_0013};
    prog_len = '0;
    $display("test: %s", name);
  endtask

  task automatic emit(logic [31:0] w);
    prog[prog_len] = w;
    prog_len = prog_len + 8'd1;
  endtask

  task automatic run_program();
    int cyc;
    run_model();
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    cyc = 0;
    while (!halted && cyc < 200) begin
      @(posedge clk);
      #1;
      cyc++;
    end
    check_true(halted, "core did not halt within 200 cycles");
    check_true(exp_q.size() == 0, "expected retire records were never seen");
  endtask

  task automatic test_addi_lui_chain();
    logic [4:0]  prev;
    logic [4:0]  rd;
    logic [31:0] sel;
    begin_test("chained addi and lui");
    prev = rand_reg();
    emit(enc_lui(prev, rand_imm20()));
    // each addi reads the register written just before it
    for (int i = 0; i < 12; i++) begin
      sel = take_bits(2);
      rd = rand_reg();
      if (sel[1:0] == 2'b00) begin
        emit(enc_lui(rd, rand_imm20()));
      end else begin
        emit(enc_addi(rd, prev, rand_imm12()));
      end
      prev = rd;
    end
    emit(32'h0010_0073);
    run_program();
  endtask

  task automatic test_auipc();
    logic [4:0] rd;
    begin_test("auipc");
    for (int i = 0; i < 6; i++) begin
      rd = rand_reg();
      emit(enc_auipc(rd, rand_imm20()));
    end
    emit(enc_addi(rand_reg(), rd, rand_imm12()));
    emit(32'h0010_0073);
    run_program();
  endtask

  task automatic test_jal();
    begin_test("jal forward and backward");
    emit(enc_addi(5'd3, 5'd0, rand_imm12()));
    emit(enc_jal(5'd1, 21'd16));
    // skipped words
    emit(enc_addi(5'd3, 5'd3, 12'd1));
    emit(32'h0010_0073);
    // backward target
    emit(32'h0010_0073);
    emit(enc_addi(5'd4, 5'd1, 12'd0));
    emit(enc_jal(rand_reg(), 21'h1f_fff8));
    emit(enc_addi(5'd3, 5'd3, 12'd5));
    run_program();
  endtask

  task automatic test_x0();
    begin_test("x0 stays zero");
    emit(enc_addi(5'd3, 5'd0, rand_imm12()));
    emit(enc_addi(5'd0, 5'd3, rand_imm12()));
    emit(enc_lui(5'd0, rand_imm20()));
    emit(enc_addi(5'd4, 5'd0, 12'd5));
    emit(enc_addi(5'd5, 5'd0, rand_imm12()));
    emit(32'h0010_0073);
    run_program();
  endtask

  task automatic test_unknown_words();
    begin_test("unknown words");
    emit(enc_addi(5'd5, 5'd0, rand_imm12()));
    // add x5, x5, x5
    emit({7'b0000000, 5'd5, 5'd5, 3'b000, 5'd5, 7'b0110011});
    emit(enc_addi(5'd6, 5'd5, 12'd1));
    // slti x6, x5, 1
    emit({12'h001, 5'd5, 3'b010, 5'd6, 7'b0010011});
    emit(enc_addi(5'd7, 5'd6, 12'd0));
    // ecall
    emit(32'h0000_0073);
    emit(32'h0010_0073);
    run_program();
  endtask

  task automatic test_ebreak_halt();
    logic [63:0] addr0;
    begin_test("ebreak halts the core");
    emit(enc_addi(5'd1, 5'd0, rand_imm12()));
    emit(32'h0010_0073);
    emit(enc_addi(5'd2, 5'd0, 12'd7));
    emit(enc_addi(5'd3, 5'd0, 12'd9));
    run_program();
    addr0 = inst_addr;
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      #1;
      check_value("inst_addr", inst_addr, addr0);
      check_true(!retire_valid, "instruction retired after halt");
      check_true(halted, "halted dropped before reset");
    end
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    prog = '{default: 32'h0000_0013};
    prog_len = '0;
    lfsr_state = 32'ha07b_3af7;
    errors = 0;
    checks = 0;
    test_addi_lui_chain();
    test_auipc();
    test_jal();
    test_x0();
    test_unknown_words();
    test_ebreak_halt();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // upper bound on the whole run
  initial begin
    #(n_tests * 220 * 10);
    $display("Watchdog expired, tests did not finish in time (errors so far: %0d)", errors);
    $display("TB FAILED");
    $finish;
  end

endmodule
